// File: build.f
dcache_pkg.sv
lsu_pkg.sv
main_mem.sv
mmio_regs.sv
dcache_core.sv
lsu_align.sv
dcache_top.sv
tb_dcache.sv

// File: tb_dcache.sv
`timescale 1ns/1ns

module tb_dcache import dcache_pkg::*, lsu_pkg::*; ();

    localparam int timeout_cycles = 50;
    localparam int max_entries = 64;

    logic              clk;
    logic              rst;
    logic              req;
    mem_op_e           op;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic              ack;
    logic [data_w-1:0] rdata;

    // stimulus table, one access per entry
    mem_op_e           tab_op    [max_entries];
    logic [addr_w-1:0] tab_addr  [max_entries];
    logic [data_w-1:0] tab_wdata [max_entries];
    logic [data_w-1:0] tab_exp   [max_entries];
    logic              tab_chk   [max_entries];
    int                n_entries;

    dcache_top i_dcache_top (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .op    (op),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h got %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_entry(input mem_op_e o, input logic [addr_w-1:0] a,
                             input logic [data_w-1:0] d, input logic [data_w-1:0] e,
                             input logic c);
        tab_op[n_entries]    = o;
        tab_addr[n_entries]  = a;
        tab_wdata[n_entries] = d;
        tab_exp[n_entries]   = e;
        tab_chk[n_entries]   = c;
        n_entries++;
    endtask

    // poll ack at the falling edge until it reaches level
    task automatic wait_ack(input logic level, input int idx);
        int n;
        n = 0;
        @(negedge clk);
        while (ack !== level && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (ack !== level) begin
            if (level) begin
                $display("ack did not rise within %0d cycles at entry %0d",
                         timeout_cycles, idx);
            end else begin
                $display("ack did not fall within %0d cycles at entry %0d",
                         timeout_cycles, idx);
            end
            $display("Test FAILED");
            $fatal(1, "handshake timeout");
        end
    endtask

    task automatic run_entry(input int idx);
        // ack must stay low between requests
        @(negedge clk);
        check_value("ack", 32'h0, {31'b0, ack});
        @(posedge clk);
        req   <= 1'b1;
        op    <= tab_op[idx];
        addr  <= tab_addr[idx];
        wdata <= tab_wdata[idx];
        wait_ack(1'b1, idx);
        if (tab_chk[idx]) begin
            check_value("rdata", tab_exp[idx], rdata);
        end
        @(posedge clk);
        req <= 1'b0;
        wait_ack(1'b0, idx);
    endtask

    task automatic build_table();
        n_entries = 0;
        // never written locations read zero
        add_entry(op_lw,  20'h00040, 32'h0, 32'h00000000, 1'b1);
        add_entry(op_lw,  20'h01234, 32'h0, 32'h00000000, 1'b1);
        add_entry(op_lbu, 20'h00083, 32'h0, 32'h00000000, 1'b1);
        add_entry(op_lw,  20'hf0000, 32'h0, 32'h00000000, 1'b1);

        // store then load
        add_entry(op_sw,  20'h00010, 32'hdeadbeef, 32'h0, 1'b0);
        add_entry(op_lw,  20'h00010, 32'h0, 32'hdeadbeef, 1'b1);

        // byte stores at every offset
        add_entry(op_sw,  20'h00020, 32'h11223344, 32'h0, 1'b0);
        add_entry(op_sb,  20'h00020, 32'hffffffa5, 32'h0, 1'b0);
        add_entry(op_sb,  20'h00021, 32'h00000081, 32'h0, 1'b0);
        add_entry(op_sb,  20'h00022, 32'h1234567e, 32'h0, 1'b0);
        add_entry(op_sb,  20'h00023, 32'h000000c3, 32'h0, 1'b0);
        add_entry(op_lw,  20'h00020, 32'h0, 32'hc37e81a5, 1'b1);
        add_entry(op_lb,  20'h00020, 32'h0, 32'hffffffa5, 1'b1);
        add_entry(op_lbu, 20'h00020, 32'h0, 32'h000000a5, 1'b1);
        add_entry(op_lb,  20'h00021, 32'h0, 32'hffffff81, 1'b1);
        add_entry(op_lbu, 20'h00021, 32'h0, 32'h00000081, 1'b1);
        add_entry(op_lb,  20'h00022, 32'h0, 32'h0000007e, 1'b1);
        add_entry(op_lbu, 20'h00022, 32'h0, 32'h0000007e, 1'b1);
        add_entry(op_lb,  20'h00023, 32'h0, 32'hffffffc3, 1'b1);
        add_entry(op_lbu, 20'h00023, 32'h0, 32'h000000c3, 1'b1);
        add_entry(op_lh,  20'h00020, 32'h0, 32'hffff81a5, 1'b1);
        add_entry(op_lhu, 20'h00020, 32'h0, 32'h000081a5, 1'b1);
        add_entry(op_lh,  20'h00022, 32'h0, 32'hffffc37e, 1'b1);
        add_entry(op_lhu, 20'h00022, 32'h0, 32'h0000c37e, 1'b1);

        // half-word stores at both offsets
        add_entry(op_sw,  20'h00024, 32'haabbccdd, 32'h0, 1'b0);
        add_entry(op_sh,  20'h00024, 32'h12348001, 32'h0, 1'b0);
        add_entry(op_sh,  20'h00026, 32'h00007f02, 32'h0, 1'b0);
        add_entry(op_lw,  20'h00024, 32'h0, 32'h7f028001, 1'b1);
        add_entry(op_lh,  20'h00024, 32'h0, 32'hffff8001, 1'b1);
        add_entry(op_lhu, 20'h00024, 32'h0, 32'h00008001, 1'b1);
        add_entry(op_lh,  20'h00026, 32'h0, 32'h00007f02, 1'b1);
        add_entry(op_lhu, 20'h00026, 32'h0, 32'h00007f02, 1'b1);
        add_entry(op_lb,  20'h00026, 32'h0, 32'h00000002, 1'b1);
        add_entry(op_lb,  20'h00027, 32'h0, 32'h0000007f, 1'b1);

        // same index 0, different tags
        add_entry(op_sw,  20'h00100, 32'ha0a0a0a0, 32'h0, 1'b0);
        add_entry(op_sw,  20'h00180, 32'hb1b1b1b1, 32'h0, 1'b0);
        add_entry(op_lw,  20'h00100, 32'h0, 32'ha0a0a0a0, 1'b1);
        add_entry(op_lw,  20'h00180, 32'h0, 32'hb1b1b1b1, 1'b1);
        add_entry(op_sw,  20'h04100, 32'hc2c2c2c2, 32'h0, 1'b0);
        add_entry(op_lw,  20'h00100, 32'h0, 32'ha0a0a0a0, 1'b1);
        add_entry(op_lw,  20'h04100, 32'h0, 32'hc2c2c2c2, 1'b1);

        // scratch registers, with cached words at matching low bits
        add_entry(op_sw,  20'h00004, 32'h0badf00d, 32'h0, 1'b0);
        add_entry(op_sw,  20'hf0000, 32'h10000001, 32'h0, 1'b0);
        add_entry(op_sw,  20'hf0004, 32'h20000002, 32'h0, 1'b0);
        add_entry(op_sw,  20'hf0008, 32'h30000003, 32'h0, 1'b0);
        add_entry(op_sw,  20'hf000c, 32'h40000004, 32'h0, 1'b0);
        add_entry(op_lw,  20'hf0000, 32'h0, 32'h10000001, 1'b1);
        add_entry(op_lw,  20'hf0004, 32'h0, 32'h20000002, 1'b1);
        add_entry(op_lw,  20'hf0008, 32'h0, 32'h30000003, 1'b1);
        add_entry(op_lw,  20'hf000c, 32'h0, 32'h40000004, 1'b1);
        add_entry(op_sb,  20'hf0009, 32'h0000005a, 32'h0, 1'b0);
        add_entry(op_lw,  20'hf0008, 32'h0, 32'h30005a03, 1'b1);
        add_entry(op_lh,  20'hf000e, 32'h0, 32'h00004000, 1'b1);
        add_entry(op_lw,  20'h00004, 32'h0, 32'h0badf00d, 1'b1);
        add_entry(op_lw,  20'h0000c, 32'h0, 32'h00000000, 1'b1);
    endtask

    initial begin
        clk   = 1'b0;
        rst   = 1'b1;
        req   = 1'b0;
        op    = op_lw;
        addr  = '0;
        wdata = '0;
        build_table();

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("ack", 32'h0, {31'b0, ack});

        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end

        $display("Test OK");
        $finish;
    end

endmodule

// File: dcache_top.sv
`timescale 1ns/1ns

module dcache_top import dcache_pkg::*, lsu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  mem_op_e           op,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] wdata,
    output logic              ack,
    output logic [data_w-1:0] rdata
);

    // word port to the cache
    logic              core_req;
    logic              core_we;
    logic [addr_w-1:0] core_addr;
    logic [data_w-1:0] core_wdata;
    logic              core_ack;
    logic [data_w-1:0] core_rdata;

    // word port to the scratch registers
    logic                  mmio_req;
    logic                  mmio_we;
    logic [mmio_idx_w-1:0] mmio_idx;
    logic [data_w-1:0]     mmio_wdata;
    logic                  mmio_ack;
    logic [data_w-1:0]     mmio_rdata;

    // cache to backing RAM
    logic [mem_addr_w-1:0] mem_addr;
    logic [data_w-1:0]     mem_wdata;
    logic                  mem_we;
    logic [data_w-1:0]     mem_rdata;

    lsu_align i_lsu_align (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .op         (op),
        .addr       (addr),
        .wdata      (wdata),
        .ack        (ack),
        .rdata      (rdata),
        .core_req   (core_req),
        .core_we    (core_we),
        .core_addr  (core_addr),
        .core_wdata (core_wdata),
        .core_ack   (core_ack),
        .core_rdata (core_rdata),
        .mmio_req   (mmio_req),
        .mmio_we    (mmio_we),
        .mmio_idx   (mmio_idx),
        .mmio_wdata (mmio_wdata),
        .mmio_ack   (mmio_ack),
        .mmio_rdata (mmio_rdata)
    );

    dcache_core i_dcache_core (
        .clk       (clk),
        .rst       (rst),
        .req       (core_req),
        .we        (core_we),
        .addr      (core_addr),
        .wdata     (core_wdata),
        .ack       (core_ack),
        .rdata     (core_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_rdata (mem_rdata)
    );

    mmio_regs i_mmio_regs (
        .clk   (clk),
        .rst   (rst),
        .req   (mmio_req),
        .we    (mmio_we),
        .idx   (mmio_idx),
        .wdata (mmio_wdata),
        .ack   (mmio_ack),
        .rdata (mmio_rdata)
    );

    main_mem i_main_mem (
        .clk   (clk),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .we    (mem_we),
        .rdata (mem_rdata)
    );

endmodule

// File: lsu_align.sv
`timescale 1ns/1ns

module lsu_align import dcache_pkg::*, lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  mem_op_e               op,
    input  logic [addr_w-1:0]     addr,
    input  logic [data_w-1:0]     wdata,
    output logic                  ack,
    output logic [data_w-1:0]     rdata,
    output logic                  core_req,
    output logic                  core_we,
    output logic [addr_w-1:0]     core_addr,
    output logic [data_w-1:0]     core_wdata,
    input  logic                  core_ack,
    input  logic [data_w-1:0]     core_rdata,
    output logic                  mmio_req,
    output logic                  mmio_we,
    output logic [mmio_idx_w-1:0] mmio_idx,
    output logic [data_w-1:0]     mmio_wdata,
    input  logic                  mmio_ack,
    input  logic [data_w-1:0]     mmio_rdata
);

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_read_rel,
        st_write,
        st_write_rel,
        st_resp
    } state_e;

    state_e state;

    logic              tgt_req;
    logic              tgt_we;
    logic              tgt_ack;
    logic [data_w-1:0] tgt_rdata;
    logic              is_mmio;
    logic              is_store;
    logic [data_w-1:0] rd_word;
    logic [data_w-1:0] load_word;
    logic [data_w-1:0] merged;
    logic [15:0]       ld_half;
    logic [7:0]        ld_byte;

    assign is_mmio   = (addr[addr_w-1:mmio_sel_lsb] == mmio_sel);
    assign is_store  = op inside {op_sb, op_sh, op_sw};
    assign tgt_ack   = is_mmio ? mmio_ack : core_ack;
    assign tgt_rdata = is_mmio ? mmio_rdata : core_rdata;

    // only one target sees req
    assign core_req   = tgt_req && !is_mmio;
    assign core_we    = tgt_we;
    assign core_addr  = {addr[addr_w-1:2], 2'b00};
    assign core_wdata = merged;
    assign mmio_req   = tgt_req && is_mmio;
    assign mmio_we    = tgt_we;
    assign mmio_idx   = addr[2 +: mmio_idx_w];
    assign mmio_wdata = merged;

    // load field extraction
    always_comb begin
        ld_half = addr[1] ? rd_word[31:16] : rd_word[15:0];
        ld_byte = rd_word[8*addr[1:0] +: 8];
        case (op)
            op_lh:   load_word = {{16{ld_half[15]}}, ld_half};
            op_lhu:  load_word = {16'h0000, ld_half};
            op_lb:   load_word = {{24{ld_byte[7]}}, ld_byte};
            op_lbu:  load_word = {24'h000000, ld_byte};
            default: load_word = rd_word;
        endcase
    end

    // store merge into the word read back
    always_comb begin
        merged = rd_word;
        case (op)
            op_sw:   merged = wdata;
            op_sh:   merged[16*addr[1] +: 16] = wdata[15:0];
            op_sb:   merged[8*addr[1:0] +: 8] = wdata[7:0];
            default: merged = rd_word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            ack     <= 1'b0;
            tgt_req <= 1'b0;
            tgt_we  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (req) begin
                        tgt_req <= 1'b1;
                        tgt_we  <= 1'b0;
                        state   <= st_read;
                    end
                end
                st_read: begin
                    if (tgt_ack) begin
                        tgt_req <= 1'b0;
                        state   <= st_read_rel;
                    end
                end
                st_read_rel: begin
                    if (!tgt_ack && is_store) begin
                        tgt_req <= 1'b1;
                        tgt_we  <= 1'b1;
                        state   <= st_write;
                    end else if (!tgt_ack) begin
                        ack   <= 1'b1;
                        state <= st_resp;
                    end
                end
                st_write: begin
                    if (tgt_ack) begin
                        tgt_req <= 1'b0;
                        state   <= st_write_rel;
                    end
                end
                st_write_rel: begin
                    if (!tgt_ack) begin
                        tgt_we <= 1'b0;
                        ack    <= 1'b1;
                        state  <= st_resp;
                    end
                end
                st_resp: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // a store returns the word it wrote
    always_ff @(posedge clk) begin
        if ((state == st_read) && tgt_ack) begin
            rd_word <= tgt_rdata;
        end
        if ((state == st_read_rel) && !tgt_ack) begin
            rdata <= is_store ? merged : load_word;
        end
    end

endmodule

// File: dcache_core.sv
`timescale 1ns/1ns

module dcache_core import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  logic                  we,
    input  logic [addr_w-1:0]     addr,
    input  logic [data_w-1:0]     wdata,
    output logic                  ack,
    output logic [data_w-1:0]     rdata,
    output logic [mem_addr_w-1:0] mem_addr,
    output logic [data_w-1:0]     mem_wdata,
    output logic                  mem_we,
    input  logic [data_w-1:0]     mem_rdata
);

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_writeback,
        st_fill,
        st_fill_wait,
        st_done
    } state_e;

    state_e state;

    logic [line_n-1:0] valid_q;
    logic [line_n-1:0] dirty_q;
    logic [tag_w-1:0]  tag_mem  [line_n];
    logic [data_w-1:0] data_mem [line_n];

    // line read registered in idle, compared in lookup
    logic              line_valid;
    logic              line_dirty;
    logic [tag_w-1:0]  line_tag;
    logic [data_w-1:0] line_data;

    logic [index_w-1:0] index;
    logic [tag_w-1:0]   tag;
    logic               hit;
    logic               victim;
    logic               hit_wr;
    logic               fill_done;

    assign index     = addr[byte_off_w +: index_w];
    assign tag       = addr[byte_off_w + index_w +: tag_w];
    assign hit       = line_valid && (line_tag == tag);
    assign victim    = line_valid && line_dirty && (line_tag != tag);
    assign hit_wr    = (state == st_lookup) && hit && we;
    assign fill_done = (state == st_fill_wait);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            ack     <= 1'b0;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (req) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (hit) begin
                        ack   <= 1'b1;
                        state <= st_done;
                    end else if (victim) begin
                        state <= st_writeback;
                    end else begin
                        state <= st_fill;
                    end
                end
                st_writeback: begin
                    state <= st_fill;
                end
                st_fill: begin
                    state <= st_fill_wait;
                end
                st_fill_wait: begin
                    ack   <= 1'b1;
                    state <= st_done;
                end
                st_done: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase

            if (hit_wr) begin
                dirty_q[index] <= 1'b1;
            end
            // read fill stays clean
            if (fill_done) begin
                valid_q[index] <= 1'b1;
                dirty_q[index] <= we;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            line_valid <= valid_q[index];
            line_dirty <= dirty_q[index];
            line_tag   <= tag_mem[index];
            line_data  <= data_mem[index];
        end
        if (hit_wr) begin
            data_mem[index] <= wdata;
        end
        if (fill_done) begin
            tag_mem[index]  <= tag;
            data_mem[index] <= we ? wdata : mem_rdata;
        end
        if ((state == st_lookup) && hit) begin
            rdata <= line_data;
        end
        if (fill_done) begin
            rdata <= mem_rdata;
        end
    end

    // victim address during writeback, fill address otherwise
    always_comb begin
        mem_addr  = {tag, index};
        mem_wdata = line_data;
        mem_we    = 1'b0;
        if (state == st_writeback) begin
            mem_addr = {line_tag, index};
            mem_we   = 1'b1;
        end
    end

endmodule

// File: mmio_regs.sv
`timescale 1ns/1ns

module mmio_regs import dcache_pkg::*, lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  logic                  we,
    input  logic [mmio_idx_w-1:0] idx,
    input  logic [data_w-1:0]     wdata,
    output logic                  ack,
    output logic [data_w-1:0]     rdata
);

    logic [data_w-1:0] regs [mmio_reg_n];
    logic              start;

    // one access per request, ack held until req drops
    assign start = req && !ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
            for (int i = 0; i < mmio_reg_n; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (start) begin
                ack <= 1'b1;
                if (we) begin
                    regs[idx] <= wdata;
                end
            end else if (!req) begin
                ack <= 1'b0;
            end
        end
    end

    // old value on a write, same as a plain read
    always_ff @(posedge clk) begin
        if (start) begin
            rdata <= regs[idx];
        end
    end

endmodule

// File: main_mem.sv
`timescale 1ns/1ns

module main_mem import dcache_pkg::*; (
    input  logic                  clk,
    input  logic [mem_addr_w-1:0] addr,
    input  logic [data_w-1:0]     wdata,
    input  logic                  we,
    output logic [data_w-1:0]     rdata
);

    logic [data_w-1:0] mem [mem_words];

    // unwritten words read as zero
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = '0;
        end
    end

    // write on we, read data registered one cycle after addr
    always @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// File: lsu_pkg.sv
package lsu_pkg;

    // cpu memory operations
    typedef enum logic [2:0] {
        op_lb,
        op_lh,
        op_lw,
        op_lbu,
        op_lhu,
        op_sb,
        op_sh,
        op_sw
    } mem_op_e;

    // uncached region when addr[19:16] is all ones
    localparam logic [3:0] mmio_sel = 4'hf;
    localparam int mmio_sel_lsb = 16;

    // scratch register bank
    localparam int mmio_reg_n = 4;
    localparam int mmio_idx_w = $clog2(mmio_reg_n);

endpackage

// File: dcache_pkg.sv
package dcache_pkg;

    // cpu side
    localparam int addr_w = 20;
    localparam int data_w = 32;

    // byte address bits inside one word
    localparam int byte_off_w = 2;

    // byte address span of main memory, 64 KB
    localparam int mem_span_w = 16;
    localparam int mem_addr_w = mem_span_w - byte_off_w;
    localparam int mem_words = 1 << mem_addr_w;

    // direct-mapped geometry, one word per line
    localparam int index_w = 5;
    localparam int line_n = 1 << index_w;

    // tag is addr[mem_span_w-1 : byte_off_w+index_w]
    localparam int tag_w = mem_span_w - byte_off_w - index_w;

endpackage
